//--- hdl/issue_pkg.sv
package issue_pkg;

  // register ids index x0..x31
  localparam int reg_id_w = 5;

  // major opcodes seen by the issue stage
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_load   = 7'b0000011;

  // funct7 of the M extension ops within OP
  localparam logic [6:0] funct7_mul = 7'b0000001;

  // register-register layout
  typedef struct packed {
    logic [6:0]          funct7;
    logic [reg_id_w-1:0] rs2;
    logic [reg_id_w-1:0] rs1;
    logic [2:0]          funct3;
    logic [reg_id_w-1:0] rd;
    logic [6:0]          opcode;
  } instr_r_t;

  // immediate layout used by OP-IMM and LOAD
  typedef struct packed {
    logic [11:0]         imm;
    logic [reg_id_w-1:0] rs1;
    logic [2:0]          funct3;
    logic [reg_id_w-1:0] rd;
    logic [6:0]          opcode;
  } instr_i_t;

  // one instruction word, two ways to read it
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

endpackage

//--- hdl/issue_decode.sv
`timescale 1ns/1ps

module issue_decode (
  input  logic                           instr_v_i,
  input  issue_pkg::instr_u              instr_i,
  input  logic                           dependency_i,

  output logic [issue_pkg::reg_id_w-1:0] src1_id_o,
  output logic [issue_pkg::reg_id_w-1:0] src2_id_o,
  output logic [issue_pkg::reg_id_w-1:0] dest_id_o,
  output logic                           reads_rs1_o,
  output logic                           reads_rs2_o,
  output logic                           writes_rd_o,

  output logic                           issue_o,
  output logic                           stall_o,
  output logic                           score_o,
  output logic                           mul_v_o,
  output logic                           load_req_v_o
);

  import issue_pkg::*;

  logic [6:0] opcode;
  logic       is_op;
  logic       is_op_imm;
  logic       is_load;
  logic       is_mul;

  // opcode sits in the same bits for both views
  assign opcode    = instr_i.r.opcode;
  assign is_op     = (opcode == opc_op);
  assign is_op_imm = (opcode == opc_op_imm);
  assign is_load   = (opcode == opc_load);
  assign is_mul    = is_op && (instr_i.r.funct7 == funct7_mul);

  // operand fields and use flags per instruction class
  always_comb begin
    src1_id_o   = '0;
    src2_id_o   = '0;
    dest_id_o   = '0;
    reads_rs1_o = 1'b0;
    reads_rs2_o = 1'b0;
    writes_rd_o = 1'b0;
    if (is_op) begin
      src1_id_o   = instr_i.r.rs1;
      src2_id_o   = instr_i.r.rs2;
      dest_id_o   = instr_i.r.rd;
      reads_rs1_o = 1'b1;
      reads_rs2_o = 1'b1;
      writes_rd_o = 1'b1;
    end else if (is_op_imm || is_load) begin
      src1_id_o   = instr_i.i.rs1;
      dest_id_o   = instr_i.i.rd;
      reads_rs1_o = 1'b1;
      writes_rd_o = 1'b1;
    end
  end

  // a valid instruction either goes or is rejected in the same cycle
  assign issue_o = instr_v_i & ~dependency_i;
  assign stall_o = instr_v_i & dependency_i;

  // only long-latency results are tracked
  assign score_o      = issue_o & (is_mul | is_load);
  assign mul_v_o      = issue_o & is_mul;
  assign load_req_v_o = issue_o & is_load;

endmodule

//--- hdl/scoreboard.sv
`timescale 1ns/1ps

module scoreboard #(
  parameter int els_p            = 32,
  parameter int num_clear_port_p = 2
) (
  input  logic                                                 clk_i,
  input  logic                                                 reset_i,

  input  logic [issue_pkg::reg_id_w-1:0]                       src1_id_i,
  input  logic [issue_pkg::reg_id_w-1:0]                       src2_id_i,
  input  logic [issue_pkg::reg_id_w-1:0]                       dest_id_i,

  input  logic                                                 reads_rs1_i,
  input  logic                                                 reads_rs2_i,
  input  logic                                                 writes_rd_i,

  input  logic                                                 score_i,
  input  logic [num_clear_port_p-1:0]                          clear_i,
  input  logic [num_clear_port_p-1:0][issue_pkg::reg_id_w-1:0] clear_id_i,

  output logic                                                 dependency_o
);

  logic [els_p-1:0]                       busy_r;
  logic [num_clear_port_p-1:0][els_p-1:0] clear_by_port;
  logic [els_p-1:0]                       clear_combined;
  logic [els_p-1:0]                       score_onehot;
  logic                                   depend_on_rs1;
  logic                                   depend_on_rs2;
  logic                                   depend_on_rd;

  // one-hot decode of each clear port
  always_comb begin
    for (int p = 0; p < num_clear_port_p; p++) begin
      clear_by_port[p] = '0;
      if (clear_i[p]) begin
        clear_by_port[p][clear_id_i[p]] = 1'b1;
      end
    end
  end

  // merge all ports into a single clear vector
  always_comb begin
    clear_combined = '0;
    for (int p = 0; p < num_clear_port_p; p++) begin
      clear_combined = clear_combined | clear_by_port[p];
    end
  end

  // x0 is hardwired zero so it never gets a busy bit
  always_comb begin
    score_onehot = '0;
    if (score_i && (dest_id_i != '0)) begin
      score_onehot[dest_id_i] = 1'b1;
    end
  end

  // score beats a clear on the same register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r <= '0;
    end else begin
      busy_r <= score_onehot | (busy_r & ~clear_combined);
    end
  end

  // clears arriving this cycle release the operand right away
  assign depend_on_rs1 = reads_rs1_i & busy_r[src1_id_i] & ~clear_combined[src1_id_i];
  assign depend_on_rs2 = reads_rs2_i & busy_r[src2_id_i] & ~clear_combined[src2_id_i];
  assign depend_on_rd  = writes_rd_i & busy_r[dest_id_i] & ~clear_combined[dest_id_i];

  assign dependency_o = depend_on_rs1 | depend_on_rs2 | depend_on_rd;

endmodule

//--- hdl/mul_pipe.sv
`timescale 1ns/1ps

module mul_pipe #(
  parameter int mul_lat_p = 3
) (
  input  logic                           clk_i,
  input  logic                           reset_i,

  input  logic                           mul_v_i,
  input  logic [issue_pkg::reg_id_w-1:0] mul_rd_i,

  output logic                           wb_v_o,
  output logic [issue_pkg::reg_id_w-1:0] wb_id_o
);

  logic [mul_lat_p-1:0]                              v_r;
  logic [mul_lat_p-1:0][issue_pkg::reg_id_w-1:0]     rd_r;

  // stage 0 takes the new op, every stage shifts each cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r <= '0;
    end else begin
      v_r[0] <= mul_v_i;
      for (int s = 1; s < mul_lat_p; s++) begin
        v_r[s] <= v_r[s-1];
      end
    end
  end

  // tags ride alongside the valid bits
  always_ff @(posedge clk_i) begin
    rd_r[0] <= mul_rd_i;
    for (int s = 1; s < mul_lat_p; s++) begin
      rd_r[s] <= rd_r[s-1];
    end
  end

  // last stage is the writeback
  assign wb_v_o  = v_r[mul_lat_p-1];
  assign wb_id_o = rd_r[mul_lat_p-1];

endmodule

//--- hdl/issue_top.sv
`timescale 1ns/1ps

module issue_top #(
  parameter int els_p            = 32,
  parameter int num_clear_port_p = 2,
  parameter int mul_lat_p        = 3
) (
  input  logic                           clk_i,
  input  logic                           reset_i,

  input  logic                           instr_v_i,
  input  issue_pkg::instr_u              instr_i,

  input  logic                           mem_resp_v_i,
  input  logic [issue_pkg::reg_id_w-1:0] mem_resp_id_i,

  output logic                           issue_o,
  output logic                           stall_o,

  output logic                           load_req_v_o,
  output logic [issue_pkg::reg_id_w-1:0] load_req_id_o,

  output logic                           wb_v_o,
  output logic [issue_pkg::reg_id_w-1:0] wb_id_o
);

  import issue_pkg::*;

  logic [reg_id_w-1:0]                       src1_id;
  logic [reg_id_w-1:0]                       src2_id;
  logic [reg_id_w-1:0]                       dest_id;
  logic                                      reads_rs1;
  logic                                      reads_rs2;
  logic                                      writes_rd;
  logic                                      dependency;
  logic                                      score;
  logic                                      mul_v;
  logic [num_clear_port_p-1:0]               clear_v;
  logic [num_clear_port_p-1:0][reg_id_w-1:0] clear_id;

  // port 0 is multiply writeback, port 1 is memory response
  assign clear_v[0]  = wb_v_o;
  assign clear_id[0] = wb_id_o;
  assign clear_v[1]  = mem_resp_v_i;
  assign clear_id[1] = mem_resp_id_i;

  // load request carries the decoded rd
  assign load_req_id_o = dest_id;

  issue_decode i_issue_decode (
    .instr_v_i    (instr_v_i),
    .instr_i      (instr_i),
    .dependency_i (dependency),
    .src1_id_o    (src1_id),
    .src2_id_o    (src2_id),
    .dest_id_o    (dest_id),
    .reads_rs1_o  (reads_rs1),
    .reads_rs2_o  (reads_rs2),
    .writes_rd_o  (writes_rd),
    .issue_o      (issue_o),
    .stall_o      (stall_o),
    .score_o      (score),
    .mul_v_o      (mul_v),
    .load_req_v_o (load_req_v_o)
  );

  scoreboard #(
    .els_p            (els_p),
    .num_clear_port_p (num_clear_port_p)
  ) i_scoreboard (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .src1_id_i    (src1_id),
    .src2_id_i    (src2_id),
    .dest_id_i    (dest_id),
    .reads_rs1_i  (reads_rs1),
    .reads_rs2_i  (reads_rs2),
    .writes_rd_i  (writes_rd),
    .score_i      (score),
    .clear_i      (clear_v),
    .clear_id_i   (clear_id),
    .dependency_o (dependency)
  );

  mul_pipe #(
    .mul_lat_p (mul_lat_p)
  ) i_mul_pipe (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .mul_v_i  (mul_v),
    .mul_rd_i (dest_id),
    .wb_v_o   (wb_v_o),
    .wb_id_o  (wb_id_o)
  );

endmodule

//--- test/issue_top_properties.sv
`timescale 1ns/1ps

module issue_top_properties (
  input logic                           clk_i,
  input logic                           reset_i,
  input logic                           instr_v_i,
  input logic                           issue_o,
  input logic                           stall_o,
  input logic                           load_req_v_o,
  input logic                           wb_v_o,
  input logic [issue_pkg::reg_id_w-1:0] wb_id_o,
  input logic                           mem_resp_v_i,
  input logic [issue_pkg::reg_id_w-1:0] mem_resp_id_i
);

  // decision is one or the other, never both
  issue_stall_excl: assert property (@(posedge clk_i) !(issue_o && stall_o))
    else $error("issue_o and stall_o high in the same cycle");

  stall_needs_valid: assert property (@(posedge clk_i) stall_o |-> instr_v_i)
    else $error("stall_o high without instr_v_i");

  // writeback and memory response must not target the same register
  clear_ports_distinct: assert property (@(posedge clk_i)
    (wb_v_o && mem_resp_v_i) |-> (wb_id_o != mem_resp_id_i))
    else $error("both clear ports hit the same register");

  quiet_in_reset: assert property (@(posedge clk_i)
    reset_i |-> !(issue_o || stall_o || load_req_v_o))
    else $error("issue outputs active during reset");

endmodule

bind issue_top issue_top_properties i_issue_top_properties (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .instr_v_i     (instr_v_i),
  .issue_o       (issue_o),
  .stall_o       (stall_o),
  .load_req_v_o  (load_req_v_o),
  .wb_v_o        (wb_v_o),
  .wb_id_o       (wb_id_o),
  .mem_resp_v_i  (mem_resp_v_i),
  .mem_resp_id_i (mem_resp_id_i)
);

//--- test/issue_top_tb.sv
`timescale 1ns/1ps

module issue_top_tb;

  import issue_pkg::*;

  localparam int mul_lat_c  = 3;
  localparam int directed_c = 60;
  localparam int random_c   = 300;

  logic                clk_i;
  logic                reset_i;
  logic                instr_v_i;
  instr_u              instr_i;
  logic                mem_resp_v_i;
  logic [reg_id_w-1:0] mem_resp_id_i;
  logic                issue_o;
  logic                stall_o;
  logic                load_req_v_o;
  logic [reg_id_w-1:0] load_req_id_o;
  logic                wb_v_o;
  logic [reg_id_w-1:0] wb_id_o;

  logic [31:0]         lfsr_q;
  logic [31:0]         shadow_busy;
  int                  cyc;
  int                  hit;
  int                  t0;
  int                  mul_due_q[$];
  logic [reg_id_w-1:0] mul_id_q[$];
  int                  mem_due_q[$];
  logic [reg_id_w-1:0] mem_id_q[$];
  int                  checks_run;
  int                  test_errors;
  int                  total_errors;
  int                  tests_run;
  int                  tests_failed;
  logic                rand_v;
  instr_u              rand_w;

  issue_top #(.mul_lat_p(mul_lat_c)) i_issue_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // galois lfsr, one step per bit handed out
  function automatic int take_bits(input int n);
    int val;
    val = 0;
    for (int k = 0; k < n; k++) begin
      val = (val << 1) | int'(lfsr_q[0]);
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  function automatic instr_u r_type_word(input logic [6:0] f7, input logic [reg_id_w-1:0] rs2,
                                         input logic [reg_id_w-1:0] rs1,
                                         input logic [reg_id_w-1:0] rd);
    instr_u u;
    u.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: 3'd0, rd: rd, opcode: opc_op};
    return u;
  endfunction

  function automatic instr_u i_type_word(input logic [6:0] opc, input logic [reg_id_w-1:0] rs1,
                                         input logic [reg_id_w-1:0] rd);
    instr_u u;
    u.i = '{imm: 12'h010, rs1: rs1, funct3: 3'd2, rd: rd, opcode: opc};
    return u;
  endfunction

  // registers come from r0..r7 so hazards show up often
  function automatic instr_u random_instr();
    int                  kind;
    logic [reg_id_w-1:0] rs1;
    logic [reg_id_w-1:0] rs2;
    logic [reg_id_w-1:0] rd;
    kind = take_bits(3);
    rs1 = 5'(take_bits(3));
    rs2 = 5'(take_bits(3));
    rd = 5'(take_bits(3));
    case (kind)
      0, 1: return r_type_word(7'd0, rs2, rs1, rd);
      2, 3: return r_type_word(funct7_mul, rs2, rs1, rd);
      4: return i_type_word(opc_op_imm, rs1, rd);
      5, 6: return i_type_word(opc_load, rs1, rd);
      default: return i_type_word(7'b1100011, rs1, rd);
    endcase
  endfunction

  task automatic compare_value(input string test, input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    checks_run++;
    assert (act === exp) else begin
      $display("** Error %s: %s expected %0h, actual %0h", test, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  // one clock of stimulus, shadow model and checks
  task automatic run_cycle(input string name, input logic v, input instr_u in_w);
    logic [31:0]         clr;
    logic [31:0]         blocked;
    logic [6:0]          opc;
    logic [reg_id_w-1:0] rd;
    logic                dep;
    logic                go;
    logic                is_mul;
    logic                is_load;
    logic                exp_wb;
    int                  due;
    @(posedge clk_i);
    #1;
    clr = '0;
    mem_resp_v_i = 1'b0;
    mem_resp_id_i = '0;
    if (mem_due_q.size() > 0 && mem_due_q[0] <= cyc) begin
      mem_resp_v_i = 1'b1;
      mem_resp_id_i = mem_id_q.pop_front();
      mem_due_q.delete(0);
      clr[mem_resp_id_i] = 1'b1;
    end
    exp_wb = (mul_due_q.size() > 0) && (mul_due_q[0] == cyc);
    if (exp_wb) begin
      clr[mul_id_q[0]] = 1'b1;
    end
    instr_v_i = v;
    instr_i = in_w;
    opc = in_w.r.opcode;
    rd = in_w.r.rd;
    is_mul = (opc == opc_op) && (in_w.r.funct7 == funct7_mul);
    is_load = (opc == opc_load);
    // a clear in this cycle already frees the register
    blocked = shadow_busy & ~clr;
    dep = 1'b0;
    if (opc == opc_op) begin
      dep = blocked[in_w.r.rs1] | blocked[in_w.r.rs2] | blocked[rd];
    end else if (opc == opc_op_imm || is_load) begin
      dep = blocked[in_w.i.rs1] | blocked[rd];
    end
    go = v & ~dep;
    #2;
    compare_value(name, "issue_o", 32'(go), 32'(issue_o));
    compare_value(name, "stall_o", 32'(v & dep), 32'(stall_o));
    compare_value(name, "load_req_v_o", 32'(go & is_load), 32'(load_req_v_o));
    if (go && is_load) begin
      compare_value(name, "load_req_id_o", 32'(rd), 32'(load_req_id_o));
    end
    compare_value(name, "wb_v_o", 32'(exp_wb), 32'(wb_v_o));
    if (exp_wb) begin
      compare_value(name, "wb_id_o", 32'(mul_id_q.pop_front()), 32'(wb_id_o));
      mul_due_q.delete(0);
    end
    // score wins over a clear, x0 is never tracked
    shadow_busy = blocked;
    if (go && (is_mul || is_load) && rd != '0) begin
      shadow_busy[rd] = 1'b1;
    end
    if (go && is_mul) begin
      mul_due_q.push_back(cyc + mul_lat_c);
      mul_id_q.push_back(rd);
    end
    if (go && is_load && rd != '0) begin
      due = cyc + 1 + take_bits(3);
      if (mem_due_q.size() > 0 && due <= mem_due_q[$]) begin
        due = mem_due_q[$] + 1;
      end
      mem_due_q.push_back(due);
      mem_id_q.push_back(rd);
    end
    cyc++;
  endtask

  // hit holds the cycle of the issue, or -1
  task automatic resend(input string name, input instr_u in_w, input int tries);
    hit = -1;
    for (int k = 0; k < tries && hit < 0; k++) begin
      run_cycle(name, 1'b1, in_w);
      if (issue_o) begin
        hit = cyc - 1;
      end
    end
  endtask

  initial begin
    #((2 + directed_c + random_c) * 8 + 200);
    $display("watchdog expired before the last test finished");
    $display("Test failures found");
    $finish;
  end

  initial begin
    lfsr_q = 32'h96f64380;
    shadow_busy = '0;
    cyc = 0;
    checks_run = 0;
    test_errors = 0;
    total_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    reset_i = 1'b1;
    instr_v_i = 1'b0;
    instr_i = '0;
    mem_resp_v_i = 1'b0;
    mem_resp_id_i = '0;
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    run_cycle("after_reset", 1'b1, r_type_word(7'd0, 5'd2, 5'd3, 5'd1));
    run_cycle("after_reset", 1'b1, i_type_word(opc_op_imm, 5'd4, 5'd2));
    run_cycle("after_reset", 1'b1, i_type_word(7'b1100011, 5'd5, 5'd5));
    run_cycle("after_reset", 1'b1, r_type_word(funct7_mul, 5'd1, 5'd2, 5'd5));
    compare_value("after_reset", "mul r5 issue_o", 32'd1, 32'(issue_o));
    finish_test("after_reset");

    // waw on r6, raw on r6, then only free sources
    run_cycle("dependency", 1'b1, r_type_word(funct7_mul, 5'd1, 5'd2, 5'd6));
    run_cycle("dependency", 1'b1, i_type_word(opc_op_imm, 5'd1, 5'd6));
    run_cycle("dependency", 1'b1, r_type_word(7'd0, 5'd6, 5'd1, 5'd3));
    run_cycle("dependency", 1'b1, r_type_word(7'd0, 5'd0, 5'd1, 5'd2));
    finish_test("dependency");

    run_cycle("mul_latency", 1'b1, r_type_word(funct7_mul, 5'd1, 5'd2, 5'd7));
    run_cycle("mul_latency", 1'b1, r_type_word(funct7_mul, 5'd1, 5'd2, 5'd8));
    run_cycle("mul_latency", 1'b1, r_type_word(funct7_mul, 5'd1, 5'd2, 5'd9));
    repeat (4) run_cycle("mul_latency", 1'b0, '0);
    finish_test("mul_latency");

    run_cycle("wb_bypass", 1'b1, r_type_word(funct7_mul, 5'd1, 5'd2, 5'd12));
    t0 = cyc - 1;
    resend("wb_bypass", r_type_word(7'd0, 5'd12, 5'd1, 5'd13), 8);
    compare_value("wb_bypass", "issue cycle", 32'(t0 + mul_lat_c), 32'(hit));
    finish_test("wb_bypass");

    run_cycle("load_response", 1'b1, i_type_word(opc_load, 5'd1, 5'd14));
    resend("load_response", r_type_word(7'd0, 5'd1, 5'd14, 5'd15), 20);
    compare_value("load_response", "dependent issued", 32'd1, 32'(hit >= 0));
    finish_test("load_response");

    run_cycle("x0_writes", 1'b1, r_type_word(funct7_mul, 5'd1, 5'd2, 5'd0));
    run_cycle("x0_writes", 1'b1, i_type_word(opc_load, 5'd1, 5'd0));
    repeat (4) run_cycle("x0_writes", 1'b1, r_type_word(7'd0, 5'd0, 5'd0, 5'd0));
    finish_test("x0_writes");

    for (int n = 0; n < random_c; n++) begin
      rand_v = (take_bits(2) != 0);
      rand_w = random_instr();
      run_cycle("random", rand_v, rand_w);
    end
    finish_test("random");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks_run, total_errors);
    if (total_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- list.f
hdl/issue_pkg.sv
hdl/issue_decode.sv
hdl/scoreboard.sv
hdl/mul_pipe.sv
hdl/issue_top.sv
test/issue_top_properties.sv
test/issue_top_tb.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, and pass only when the pass line is in the output
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f list.f --top-module issue_top_tb \
  && ./obj_dir/Vissue_top_tb | tee /dev/stderr | grep -qF 'All tests passed!' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
